//--- project.f
+incdir+include
src/fp_pkg.sv
src/vmul_pkg.sv
src/vmul_issue.sv
src/vmul_lane_mult.sv
src/vmul_lane_normalize.sv
src/vmul_writeback.sv
src/vmul_top.sv
verif/vmul_tb.sv

//--- verif/vmul_tb.sv
`timescale 1ns/1ps

`include "vmul_settings.svh"

module vmul_tb;

    localparam int READY_LIMIT = 200; // cycles allowed for one wait on op_ready
    localparam int DRAIN_LIMIT = 2000;

    logic                   clk;
    logic                   rst_n;
    logic                   op_valid;
    logic                   op_ready;
    vmul_pkg::lane_vec_t    op_a;
    vmul_pkg::lane_vec_t    op_b;
    vmul_pkg::lane_vec_t    op_c;
    vmul_pkg::reg_addr_t    op_dest_reg;
    vmul_pkg::elem_offset_t op_dest_offset;
    logic                   op_enable_macc;
    logic                   res_valid;
    logic                   res_ready;
    vmul_pkg::lane_vec_t    res_data;
    vmul_pkg::reg_addr_t    res_dest_reg;
    vmul_pkg::elem_offset_t res_dest_offset;
    logic                   macc_valid;
    logic                   macc_ready;
    vmul_pkg::lane_vec_t    macc_product;
    vmul_pkg::lane_vec_t    macc_c;
    vmul_pkg::reg_addr_t    macc_dest_reg;
    vmul_pkg::elem_offset_t macc_dest_offset;

    integer seed = 32'heb4b;
    int     data_errs;
    int     proto_errs;
    bit     ok;

    // one entry per vector operation with lane 0 in the low word
    vmul_pkg::lane_vec_t    tab_a[$];
    vmul_pkg::lane_vec_t    tab_b[$];
    vmul_pkg::lane_vec_t    tab_c[$];
    vmul_pkg::lane_vec_t    tab_exp[$];
    vmul_pkg::reg_addr_t    tab_reg[$];
    vmul_pkg::elem_offset_t tab_off[$];
    logic                   tab_macc[$];
    int                     res_q[$]; // sequence numbers still owed by each port
    int                     macc_q[$];

    vmul_top i_vmul_top (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        #1;
        res_ready = ($random(seed) % 4) != 0;
        macc_ready = ($random(seed) % 4) != 0;
    end

    task automatic add_entry(input vmul_pkg::lane_vec_t a, input vmul_pkg::lane_vec_t b,
                             input vmul_pkg::lane_vec_t c, input vmul_pkg::lane_vec_t exp,
                             input vmul_pkg::reg_addr_t dest, input vmul_pkg::elem_offset_t off,
                             input logic macc);
        tab_a.push_back(a);
        tab_b.push_back(b);
        tab_c.push_back(c);
        tab_exp.push_back(exp);
        tab_reg.push_back(dest);
        tab_off.push_back(off);
        tab_macc.push_back(macc);
    endtask

    task automatic build_table();
        // exact products, negative operands included
        add_entry({32'h3f000000, 32'hc0000000, 32'hbfc00000, 32'h3fc00000},
                  {32'h40800000, 32'hc0400000, 32'h40000000, 32'h40000000},
                  {32'h41200000, 32'hc1200000, 32'h3f800000, 32'h00000000},
                  {32'h40000000, 32'h40c00000, 32'hc0400000, 32'h40400000}, 5'd1, 3'd0, 1'b0);
        // above half, tie rounding up to even, tie staying even, below half
        add_entry({32'h3fc00001, 32'h3f800001, 32'h3f800003, 32'h3f800001},
                  {32'h3fc00001, 32'h3fc00000, 32'h3fc00000, 32'h3f800001},
                  {32'h12345678, 32'h9abcdef0, 32'h0badf00d, 32'h7f7fffff},
                  {32'h40100002, 32'h3fc00002, 32'h3fc00004, 32'h3f800002}, 5'd2, 3'd4, 1'b1);
        // lanes 0 and 1 round up across the mantissa into the next exponent
        add_entry({32'hbf800000, 32'h3fc00000, 32'hbffffffe, 32'h3ffffffe},
                  {32'hbf800000, 32'h3fc00000, 32'h3f800001, 32'h3f800001},
                  {32'h00000001, 32'h80000000, 32'h7fc00000, 32'hff800000},
                  {32'h3f800000, 32'h40100000, 32'hc0000000, 32'h40000000}, 5'd3, 3'd1, 1'b0);
        // a signed NaN payload still comes out canonical
        add_entry({32'h7f800000, 32'hff800000, 32'h7f800000, 32'hffc00123},
                  {32'hc0000000, 32'h40000000, 32'h00000000, 32'h3f800000},
                  {32'h3f800000, 32'h40000000, 32'h40400000, 32'h40800000},
                  {32'hff800000, 32'hff800000, 32'h7fc00000, 32'h7fc00000}, 5'd4, 3'd2, 1'b1);
        // overflow, underflow flush and a subnormal operand
        add_entry({32'h80000001, 32'h00800000, 32'hff000000, 32'h7f000000},
                  {32'h40000000, 32'h3f000000, 32'h7f000000, 32'h40000000},
                  {32'hdeadbeef, 32'h01234567, 32'h89abcdef, 32'h55aa55aa},
                  {32'h80000000, 32'h00000000, 32'hff800000, 32'h7f800000}, 5'd5, 3'd7, 1'b0);
    endtask

    // the second pass flips the routing and bit 4 of the register address
    function automatic vmul_pkg::reg_addr_t dest_for(input int seq);
        vmul_pkg::reg_addr_t r;
        r = tab_reg[seq % tab_reg.size()];
        if (seq >= tab_reg.size()) begin
            r[4] = ~r[4];
        end
        return r;
    endfunction

    task automatic check_word(input string name, input vmul_pkg::lane_word_t exp,
                              input vmul_pkg::lane_word_t act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            data_errs++;
        end
    endtask

    task automatic check_dest(input string port, input vmul_pkg::reg_addr_t exp_reg,
                              input vmul_pkg::reg_addr_t act_reg,
                              input vmul_pkg::elem_offset_t exp_off,
                              input vmul_pkg::elem_offset_t act_off);
        if (act_reg !== exp_reg) begin
            $display("** Error at %0t: %s_dest_reg expected %0d, got %0d",
                     $time, port, exp_reg, act_reg);
            data_errs++;
        end
        if (act_off !== exp_off) begin
            $display("** Error at %0t: %s_dest_offset expected %0d, got %0d",
                     $time, port, exp_off, act_off);
            data_errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
            data_errs++;
        end
    endtask

    task automatic check_output(input logic is_macc);
        int    seq;
        int    idx;
        string port;
        port = is_macc ? "macc" : "res";
        if (is_macc && macc_q.size() > 0) begin
            seq = macc_q.pop_front();
        end else if (!is_macc && res_q.size() > 0) begin
            seq = res_q.pop_front();
        end else begin
            $display("the %s port delivered an item at %0t that was never routed there",
                     port, $time);
            proto_errs++;
            return;
        end
        idx = seq % tab_a.size();
        for (int i = 0; i < `VMUL_NUM_LANES; i++) begin
            if (is_macc) begin
                check_word($sformatf("macc_product[%0d]", i), tab_exp[idx][i], macc_product[i]);
                check_word($sformatf("macc_c[%0d]", i), tab_c[idx][i], macc_c[i]);
            end else begin
                check_word($sformatf("res_data[%0d]", i), tab_exp[idx][i], res_data[i]);
            end
        end
        if (is_macc) begin
            check_dest(port, dest_for(seq), macc_dest_reg, tab_off[idx], macc_dest_offset);
        end else begin
            check_dest(port, dest_for(seq), res_dest_reg, tab_off[idx], res_dest_offset);
        end
    endtask

    // valid, payload and ready are all settled at the falling edge
    always @(negedge clk) begin
        if (rst_n && res_valid && res_ready) begin
            check_output(1'b0);
        end
        if (rst_n && macc_valid && macc_ready) begin
            check_output(1'b1);
        end
    end

    task automatic wait_reset_ready(output bit seen);
        int waited;
        seen = 1'b0;
        waited = 0;
        while (!seen && waited < READY_LIMIT) begin
            @(negedge clk);
            seen = op_ready;
            waited++;
        end
        if (!seen) begin
            $display("timeout: op_ready never rose after reset was released");
            proto_errs++;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic send_op(input int seq, output bit accepted);
        int   idx;
        int   waited;
        logic macc;
        idx = seq % tab_a.size();
        macc = tab_macc[idx] ^ (seq >= tab_a.size());
        op_a = tab_a[idx];
        op_b = tab_b[idx];
        op_c = tab_c[idx];
        op_dest_reg = dest_for(seq);
        op_dest_offset = tab_off[idx];
        op_enable_macc = macc;
        op_valid = 1'b1;
        if (macc) begin
            macc_q.push_back(seq);
        end else begin
            res_q.push_back(seq);
        end
        accepted = 1'b0;
        waited = 0;
        while (!accepted && waited < READY_LIMIT) begin
            @(negedge clk);
            accepted = op_ready; // transfer happens on the coming rising edge
            @(posedge clk);
            #1;
            waited++;
        end
        if (!accepted) begin
            $display("timeout at %0t: operation %0d was never accepted", $time, seq);
            proto_errs++;
        end
    endtask

    task automatic wait_drained(output bit done);
        int waited;
        waited = 0;
        while ((res_q.size() > 0 || macc_q.size() > 0) && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        done = (res_q.size() == 0) && (macc_q.size() == 0);
        if (!done) begin
            $display("timeout: %0d result and %0d multiply-add items never arrived",
                     res_q.size(), macc_q.size());
            proto_errs++;
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d value mismatches, %0d protocol failures", data_errs, proto_errs);
        if (data_errs == 0 && proto_errs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    initial begin
        $timeformat(-9, 0, " ns", 0);
        rst_n = 1'b0;
        op_valid = 1'b0;
        op_a = '0;
        op_b = '0;
        op_c = '0;
        op_dest_reg = '0;
        op_dest_offset = '0;
        op_enable_macc = 1'b0;
        res_ready = 1'b0;
        macc_ready = 1'b0;
        data_errs = 0;
        proto_errs = 0;
        build_table();
        repeat (16) begin
            @(negedge clk);
            check_flag("op_ready", 1'b0, op_ready);
            check_flag("res_valid", 1'b0, res_valid);
            check_flag("macc_valid", 1'b0, macc_valid);
        end
        @(posedge clk);
        #1;
        rst_n = 1'b1;
        wait_reset_ready(ok);
        for (int seq = 0; ok && seq < 2 * tab_a.size(); seq++) begin
            send_op(seq, ok);
        end
        op_valid = 1'b0;
        if (ok) begin
            wait_drained(ok);
        end
        repeat (10) @(posedge clk); // anything arriving now is an extra item
        finish_run();
    end

endmodule

//--- src/vmul_top.sv
`timescale 1ns/1ps

`include "vmul_settings.svh"

module vmul_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   op_valid,
    output logic                   op_ready,
    input  vmul_pkg::lane_vec_t    op_a,
    input  vmul_pkg::lane_vec_t    op_b,
    input  vmul_pkg::lane_vec_t    op_c,
    input  vmul_pkg::reg_addr_t    op_dest_reg,
    input  vmul_pkg::elem_offset_t op_dest_offset,
    input  logic                   op_enable_macc,
    output logic                   res_valid,
    input  logic                   res_ready,
    output vmul_pkg::lane_vec_t    res_data,
    output vmul_pkg::reg_addr_t    res_dest_reg,
    output vmul_pkg::elem_offset_t res_dest_offset,
    output logic                   macc_valid,
    input  logic                   macc_ready,
    output vmul_pkg::lane_vec_t    macc_product,
    output vmul_pkg::lane_vec_t    macc_c,
    output vmul_pkg::reg_addr_t    macc_dest_reg,
    output vmul_pkg::elem_offset_t macc_dest_offset
);

    logic                   advance;
    logic                   issue_valid;
    logic                   issue_macc;
    vmul_pkg::lane_vec_t    issue_a;
    vmul_pkg::lane_vec_t    issue_b;
    vmul_pkg::lane_vec_t    issue_c;
    vmul_pkg::reg_addr_t    issue_dest_reg;
    vmul_pkg::elem_offset_t issue_dest_offset;

    // each lane drives its own slice of these
    wire vmul_pkg::lane_mask_t lane_valid;
    wire vmul_pkg::lane_vec_t  lane_word;
    wire vmul_pkg::lane_vec_t  lane_c;

    vmul_issue i_vmul_issue (
        .clk,
        .rst_n,
        .op_valid,
        .op_ready,
        .op_a,
        .op_b,
        .op_c,
        .op_dest_reg,
        .op_dest_offset,
        .op_enable_macc,
        .advance,
        .issue_valid,
        .issue_a,
        .issue_b,
        .issue_c,
        .issue_dest_reg,
        .issue_dest_offset,
        .issue_macc
    );

    for (genvar i = 0; i < `VMUL_NUM_LANES; i++) begin : g_lane
        logic                 mul_valid;
        logic                 mul_sign;
        logic signed [9:0]    mul_exp;
        logic [47:0]          mul_sig;
        fp_pkg::float_class_e mul_class;
        vmul_pkg::lane_word_t mul_c;

        vmul_lane_mult i_vmul_lane_mult (
            .clk,
            .rst_n,
            .advance,
            .in_valid  (issue_valid),
            .a         (issue_a[i]),
            .b         (issue_b[i]),
            .c         (issue_c[i]),
            .mul_valid,
            .mul_sign,
            .mul_exp,
            .mul_sig,
            .mul_class,
            .mul_c
        );

        vmul_lane_normalize i_vmul_lane_normalize (
            .clk,
            .rst_n,
            .advance,
            .mul_valid,
            .mul_sign,
            .mul_exp,
            .mul_sig,
            .mul_class,
            .mul_c,
            .norm_valid (lane_valid[i]),
            .norm_word  (lane_word[i]),
            .norm_c     (lane_c[i])
        );
    end

    vmul_writeback i_vmul_writeback (
        .clk,
        .rst_n,
        .lane_valid,
        .lane_word,
        .lane_c,
        .wb_dest_reg    (issue_dest_reg),
        .wb_dest_offset (issue_dest_offset),
        .wb_macc        (issue_macc),
        .advance,
        .res_valid,
        .res_ready,
        .res_data,
        .res_dest_reg,
        .res_dest_offset,
        .macc_valid,
        .macc_ready,
        .macc_product,
        .macc_c,
        .macc_dest_reg,
        .macc_dest_offset
    );

endmodule

//--- src/vmul_writeback.sv
`timescale 1ns/1ps

module vmul_writeback (
    input  logic                   clk,
    input  logic                   rst_n,
    input  vmul_pkg::lane_mask_t   lane_valid,
    input  vmul_pkg::lane_vec_t    lane_word,
    input  vmul_pkg::lane_vec_t    lane_c,
    input  vmul_pkg::reg_addr_t    wb_dest_reg,
    input  vmul_pkg::elem_offset_t wb_dest_offset,
    input  logic                   wb_macc,
    output logic                   advance,
    output logic                   res_valid,
    input  logic                   res_ready,
    output vmul_pkg::lane_vec_t    res_data,
    output vmul_pkg::reg_addr_t    res_dest_reg,
    output vmul_pkg::elem_offset_t res_dest_offset,
    output logic                   macc_valid,
    input  logic                   macc_ready,
    output vmul_pkg::lane_vec_t    macc_product,
    output vmul_pkg::lane_vec_t    macc_c,
    output vmul_pkg::reg_addr_t    macc_dest_reg,
    output vmul_pkg::elem_offset_t macc_dest_offset
);

    // destination fields ride alongside the multiply and normalize stages of the lanes
    vmul_pkg::reg_addr_t    mul_dest_reg;
    vmul_pkg::reg_addr_t    norm_dest_reg;
    vmul_pkg::elem_offset_t mul_dest_offset;
    vmul_pkg::elem_offset_t norm_dest_offset;
    logic                   mul_macc;
    logic                   norm_macc;
    logic                   head_valid;
    logic                   res_free;
    logic                   macc_free;
    logic                   produce_res;
    logic                   produce_macc;

    assign head_valid = lane_valid[0];
    assign res_free = !res_valid || res_ready;
    assign macc_free = !macc_valid || macc_ready;
    assign advance = !head_valid || (norm_macc ? macc_free : res_free);
    assign produce_res = head_valid && !norm_macc && res_free;
    assign produce_macc = head_valid && norm_macc && macc_free;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mul_macc <= 1'b0;
            norm_macc <= 1'b0;
            res_valid <= 1'b0;
            macc_valid <= 1'b0;
        end else begin
            if (advance) begin
                mul_macc <= wb_macc;
                norm_macc <= mul_macc;
            end
            if (produce_res) begin
                res_valid <= 1'b1;
            end else if (res_ready) begin
                res_valid <= 1'b0;
            end
            if (produce_macc) begin
                macc_valid <= 1'b1;
            end else if (macc_ready) begin
                macc_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            mul_dest_reg <= wb_dest_reg;
            mul_dest_offset <= wb_dest_offset;
            norm_dest_reg <= mul_dest_reg;
            norm_dest_offset <= mul_dest_offset;
        end
        if (produce_res) begin
            res_data <= lane_word;
            res_dest_reg <= norm_dest_reg;
            res_dest_offset <= norm_dest_offset;
        end
        if (produce_macc) begin
            macc_product <= lane_word;
            macc_c <= lane_c; // the adder needs c next to the product
            macc_dest_reg <= norm_dest_reg;
            macc_dest_offset <= norm_dest_offset;
        end
    end

    // the lanes share one advance, so they must never drift apart
    a_lanes_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        (lane_valid == '0) || (lane_valid == '1));

    a_one_port: assert property (@(posedge clk) disable iff (!rst_n)
        !($rose(res_valid) && $rose(macc_valid)));

endmodule

//--- src/vmul_lane_normalize.sv
`timescale 1ns/1ps

module vmul_lane_normalize (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 advance,
    input  logic                 mul_valid,
    input  logic                 mul_sign,
    input  logic signed [9:0]    mul_exp,
    input  logic [47:0]          mul_sig,
    input  fp_pkg::float_class_e mul_class,
    input  vmul_pkg::lane_word_t mul_c,
    output logic                 norm_valid,
    output vmul_pkg::lane_word_t norm_word,
    output vmul_pkg::lane_word_t norm_c
);

    logic                top_bit;
    logic [47:0]         sig_shifted;
    logic                guard;
    logic                sticky;
    logic                round_up;
    logic [23:0]         sig_rounded;
    logic signed [9:0]   exp_adj;
    fp_pkg::float_word_u result;

    always_comb begin
        top_bit = mul_sig[47];
        // after this the leading one is always at bit 47
        sig_shifted = top_bit ? mul_sig : {mul_sig[46:0], 1'b0};
        guard = sig_shifted[23];
        sticky = |sig_shifted[22:0];
        round_up = guard && (sticky || sig_shifted[24]); // ties go to the even value
        sig_rounded = {1'b0, sig_shifted[46:24]} + 24'(round_up);

        // a carry out of the mantissa leaves zeros below it and moves only the exponent
        exp_adj = mul_exp + (top_bit ? 10'sd1 : 10'sd0) + (sig_rounded[23] ? 10'sd1 : 10'sd0);

        result.bits = '0;
        result.fields.sign = mul_sign;
        case (mul_class)
            fp_pkg::FLOAT_NAN: result.bits = fp_pkg::FLOAT_QNAN;
            fp_pkg::FLOAT_INF: result.fields.exponent = fp_pkg::FLOAT_EXP_MAX;
            fp_pkg::FLOAT_ZERO: result.fields.exponent = 8'h00;
            default: begin
                if (exp_adj >= 10'sd255) begin
                    result.fields.exponent = fp_pkg::FLOAT_EXP_MAX; // overflow
                end else if (exp_adj > 10'sd0) begin
                    result.fields.exponent = exp_adj[7:0];
                    result.fields.mantissa = sig_rounded[22:0];
                end
                // otherwise the result would be subnormal and stays signed zero
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            norm_valid <= 1'b0;
        end else if (advance) begin
            norm_valid <= mul_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            norm_word <= result.bits;
            norm_c <= mul_c;
        end
    end

    // with headroom for the shift and the rounding carry a normal product cannot reach infinity
    a_no_false_inf: assert property (@(posedge clk) disable iff (!rst_n)
        advance && mul_valid && mul_class == fp_pkg::FLOAT_NORMAL && mul_exp < 10'sd253
        |=> norm_word[30:23] != fp_pkg::FLOAT_EXP_MAX);

endmodule

//--- src/vmul_lane_mult.sv
`timescale 1ns/1ps

module vmul_lane_mult (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 advance,
    input  logic                 in_valid,
    input  vmul_pkg::lane_word_t a,
    input  vmul_pkg::lane_word_t b,
    input  vmul_pkg::lane_word_t c,
    output logic                 mul_valid,
    output logic                 mul_sign,
    output logic signed [9:0]    mul_exp,
    output logic [47:0]          mul_sig,
    output fp_pkg::float_class_e mul_class,
    output vmul_pkg::lane_word_t mul_c
);

    fp_pkg::float_word_u  a_word;
    fp_pkg::float_word_u  b_word;
    fp_pkg::float_class_e a_class;
    fp_pkg::float_class_e b_class;
    fp_pkg::float_class_e prod_class;
    logic [47:0]          prod_sig;
    logic signed [9:0]    prod_exp;

    function automatic fp_pkg::float_class_e classify(input fp_pkg::float_word_u w);
        fp_pkg::float_class_e cls;
        if (w.fields.exponent == fp_pkg::FLOAT_EXP_MAX) begin
            if (w.fields.mantissa != '0) begin
                cls = fp_pkg::FLOAT_NAN;
            end else begin
                cls = fp_pkg::FLOAT_INF;
            end
        end else if (w.fields.exponent == 8'h00) begin
            cls = fp_pkg::FLOAT_ZERO; // subnormals flush here
        end else begin
            cls = fp_pkg::FLOAT_NORMAL;
        end
        return cls;
    endfunction

    always_comb begin
        a_word.bits = a;
        b_word.bits = b;
        a_class = classify(a_word);
        b_class = classify(b_word);

        // 1.m times 1.m lies in [1, 4), so bit 47 or bit 46 is the leading one
        prod_sig = {1'b1, a_word.fields.mantissa} * {1'b1, b_word.fields.mantissa};
        prod_exp = $signed({2'b00, a_word.fields.exponent})
                 + $signed({2'b00, b_word.fields.exponent})
                 - 10'(fp_pkg::FLOAT_BIAS);

        if (a_class == fp_pkg::FLOAT_NAN || b_class == fp_pkg::FLOAT_NAN ||
            (a_class == fp_pkg::FLOAT_INF && b_class == fp_pkg::FLOAT_ZERO) ||
            (a_class == fp_pkg::FLOAT_ZERO && b_class == fp_pkg::FLOAT_INF)) begin
            prod_class = fp_pkg::FLOAT_NAN;
        end else if (a_class == fp_pkg::FLOAT_INF || b_class == fp_pkg::FLOAT_INF) begin
            prod_class = fp_pkg::FLOAT_INF;
        end else if (a_class == fp_pkg::FLOAT_ZERO || b_class == fp_pkg::FLOAT_ZERO) begin
            prod_class = fp_pkg::FLOAT_ZERO;
        end else begin
            prod_class = fp_pkg::FLOAT_NORMAL;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mul_valid <= 1'b0;
        end else if (advance) begin
            mul_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            mul_sign <= a_word.fields.sign ^ b_word.fields.sign;
            mul_exp <= prod_exp;
            mul_sig <= prod_sig;
            mul_class <= prod_class;
            mul_c <= c; // c rides along untouched for the adder
        end
    end

endmodule

//--- src/vmul_issue.sv
`timescale 1ns/1ps

module vmul_issue (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   op_valid,
    output logic                   op_ready,
    input  vmul_pkg::lane_vec_t    op_a,
    input  vmul_pkg::lane_vec_t    op_b,
    input  vmul_pkg::lane_vec_t    op_c,
    input  vmul_pkg::reg_addr_t    op_dest_reg,
    input  vmul_pkg::elem_offset_t op_dest_offset,
    input  logic                   op_enable_macc,
    input  logic                   advance,
    output logic                   issue_valid,
    output vmul_pkg::lane_vec_t    issue_a,
    output vmul_pkg::lane_vec_t    issue_b,
    output vmul_pkg::lane_vec_t    issue_c,
    output vmul_pkg::reg_addr_t    issue_dest_reg,
    output vmul_pkg::elem_offset_t issue_dest_offset,
    output logic                   issue_macc
);

    logic accept_en; // stays low until the first edge after reset
    logic load;
    logic transfer;

    // the register can take a new operation when it drains this cycle or holds nothing
    assign load = advance || !issue_valid;
    assign op_ready = accept_en && load;
    assign transfer = op_valid && op_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            accept_en <= 1'b0;
            issue_valid <= 1'b0;
        end else begin
            accept_en <= 1'b1;
            if (load) begin
                issue_valid <= transfer;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (transfer) begin
            issue_a <= op_a;
            issue_b <= op_b;
            issue_c <= op_c;
            issue_dest_reg <= op_dest_reg;
            issue_dest_offset <= op_dest_offset;
            issue_macc <= op_enable_macc;
        end
    end

    // a stalled offer must not change under the issue register
    a_op_stable: assert property (@(posedge clk) disable iff (!rst_n)
        op_valid && !op_ready |=> op_valid && $stable(op_a));

endmodule

//--- src/vmul_pkg.sv
`include "vmul_settings.svh"

package vmul_pkg;

    // destination vector register
    typedef logic [`VMUL_REG_ADDR_W-1:0] reg_addr_t;

    // position of lane 0 inside the destination register
    typedef logic [`VMUL_OFFSET_W-1:0] elem_offset_t;

    typedef logic [31:0] lane_word_t;

    // lane i sits at index i of the vector
    typedef lane_word_t [`VMUL_NUM_LANES-1:0] lane_vec_t;

    typedef logic [`VMUL_NUM_LANES-1:0] lane_mask_t; // one bit per lane

endpackage

//--- src/fp_pkg.sv
package fp_pkg;

    // field view of an IEEE 754 single-precision word
    typedef struct packed {
        logic        sign;
        logic [7:0]  exponent;
        logic [22:0] mantissa;
    } float_fields_t;

    // the same 32 bits seen raw or split into fields
    typedef union packed {
        logic [31:0]   bits;
        float_fields_t fields;
    } float_word_u;

    // subnormals are folded into zero and have no class of their own
    typedef enum logic [1:0] {
        FLOAT_ZERO,
        FLOAT_NORMAL,
        FLOAT_INF,
        FLOAT_NAN
    } float_class_e;

    localparam logic [31:0] FLOAT_QNAN = 32'h7fc00000; // canonical quiet NaN

    localparam int FLOAT_BIAS = 127;

    localparam logic [7:0] FLOAT_EXP_MAX = 8'hff; // infinity and NaN

endpackage

//--- include/vmul_settings.svh
`ifndef VMUL_SETTINGS_SVH
`define VMUL_SETTINGS_SVH

// lanes per vector operation (2 and 8 work as well)
`define VMUL_NUM_LANES 4

`define VMUL_REG_ADDR_W 5 // 32 vector registers
`define VMUL_OFFSET_W 3

`endif
